/* hdl/dispatch_pkg.sv */
package dispatch_pkg;

	localparam int DATA_W = 32;
	localparam int REG_ADDR_W = 5;
	localparam int REG_COUNT = 32;
	localparam int CMD_W = 5;

	// System register index as seen in the destination and source fields
	typedef enum logic [REG_ADDR_W-1:0] {
		SYSREG_CPUIDR = 5'd0,
		SYSREG_TIDR = 5'd2,
		SYSREG_PCR = 5'd4,
		SYSREG_SPR = 5'd5,
		SYSREG_PSR = 5'd6,
		SYSREG_PPSR = 5'd13
	} sysreg_e;

	// Processor ID in the upper half, revision in the lower
	localparam logic [DATA_W-1:0] CPUIDR_VALUE = 32'h1032_0001;
	localparam logic [DATA_W-1:0] PC_READ_OFFSET = 32'd4;
	// Bits 6, 5 and 2 drop on interrupt entry
	localparam logic [DATA_W-1:0] PSR_IRQ_CLEAR_MASK = 32'h0000_0064;

	typedef struct packed {
		logic [DATA_W-1:0] tidr;
		logic [DATA_W-1:0] pcr;
		logic [DATA_W-1:0] spr;
		logic [DATA_W-1:0] psr;
		logic [DATA_W-1:0] ppsr;
	} sysreg_view_t;

	typedef struct packed {
		logic valid;
		logic [CMD_W-1:0] cmd;
		logic [REG_ADDR_W-1:0] destination;
		logic destination_sysreg;
		logic writeback;
		logic [DATA_W-1:0] pc;
		logic [REG_ADDR_W-1:0] source0;
		logic source0_sysreg;
		logic source0_active;
		logic [DATA_W-1:0] source1;
		logic source1_sysreg;
		logic source1_active;
		logic source1_imm;
	} instr_t;

	typedef struct packed {
		logic [CMD_W-1:0] cmd;
		logic [REG_ADDR_W-1:0] destination;
		logic destination_sysreg;
		logic writeback;
		logic [DATA_W-1:0] source0;
		logic [DATA_W-1:0] source1;
		logic [DATA_W-1:0] pc;
	} issued_t;

endpackage

/* hdl/writeback_if.sv */
`timescale 1ns/1ps

// Result returning from the last pipeline stage, one-cycle strobe
interface writeback_if;

	logic valid;
	logic [dispatch_pkg::DATA_W-1:0] data;
	logic [dispatch_pkg::REG_ADDR_W-1:0] destination;
	logic destination_sysreg;
	logic writeback;
	logic spr_writeback;
	logic [dispatch_pkg::DATA_W-1:0] spr;
	logic [dispatch_pkg::DATA_W-1:0] pc;

	modport source (
		output valid, data, destination, destination_sysreg,
		output writeback, spr_writeback, spr, pc
	);

	modport sink (
		input valid, data, destination, destination_sysreg,
		input writeback, spr_writeback, spr, pc
	);

endinterface

/* hdl/general_register_file.sv */
`timescale 1ns/1ps

module general_register_file (
	input logic iCLOCK,
	input logic inRESET,
	input logic event_hold,
	writeback_if.sink wb,
	input logic [dispatch_pkg::REG_ADDR_W-1:0] rd0_addr,
	output logic [dispatch_pkg::DATA_W-1:0] rd0_data,
	input logic [dispatch_pkg::REG_ADDR_W-1:0] rd1_addr,
	output logic [dispatch_pkg::DATA_W-1:0] rd1_data
);

	logic [dispatch_pkg::DATA_W-1:0] regs [dispatch_pkg::REG_COUNT];
	logic wr_en;

	// General destination only, blocked during hold
	assign wr_en = wb.valid && wb.writeback && !wb.destination_sysreg && !event_hold;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < dispatch_pkg::REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb.destination] <= wb.data;
		end
	end

	// Asynchronous reads, same-cycle writes come through forwarding
	assign rd0_data = regs[rd0_addr];
	assign rd1_data = regs[rd1_addr];

endmodule

/* hdl/system_register_bank.sv */
`timescale 1ns/1ps

module system_register_bank (
	input logic iCLOCK,
	input logic inRESET,
	input logic event_hold,
	input logic event_irq_enter,
	input logic event_irq_return,
	input logic pcr_set,
	input logic [dispatch_pkg::DATA_W-1:0] event_pcr,
	writeback_if.sink wb,
	output dispatch_pkg::sysreg_view_t regs
);

	logic [dispatch_pkg::DATA_W-1:0] tidr;
	logic [dispatch_pkg::DATA_W-1:0] pcr;
	logic [dispatch_pkg::DATA_W-1:0] spr;
	logic [dispatch_pkg::DATA_W-1:0] psr;
	logic [dispatch_pkg::DATA_W-1:0] ppsr;

	logic sys_wr;
	logic tidr_wr;
	logic spr_wr;
	logic spr_direct;
	logic psr_wr;
	logic ppsr_wr;

	// Named write to a system register
	assign sys_wr = wb.valid && wb.writeback && wb.destination_sysreg && !event_hold;
	assign tidr_wr = sys_wr && (wb.destination == dispatch_pkg::SYSREG_TIDR);
	assign spr_wr = sys_wr && (wb.destination == dispatch_pkg::SYSREG_SPR);
	assign psr_wr = sys_wr && (wb.destination == dispatch_pkg::SYSREG_PSR);
	assign ppsr_wr = sys_wr && (wb.destination == dispatch_pkg::SYSREG_PPSR);
	assign spr_direct = wb.valid && wb.spr_writeback && !event_hold;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			tidr <= '0;
		end else if (tidr_wr) begin
			tidr <= wb.data;
		end
	end

	// Event load wins over the retiring pc
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pcr <= '0;
		end else if (pcr_set) begin
			pcr <= event_pcr;
		end else if (wb.valid && !event_hold) begin
			pcr <= wb.pc;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			spr <= '0;
		end else if (spr_direct) begin
			spr <= wb.spr;
		end else if (spr_wr) begin
			spr <= wb.data;
		end
	end

	// Interrupt entry masks, return restores from PPSR
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			psr <= '0;
		end else if (event_irq_enter) begin
			psr <= psr & ~dispatch_pkg::PSR_IRQ_CLEAR_MASK;
		end else if (event_irq_return) begin
			psr <= ppsr;
		end else if (psr_wr) begin
			psr <= wb.data;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			ppsr <= '0;
		end else if (event_irq_enter) begin
			ppsr <= psr;
		end else if (ppsr_wr) begin
			ppsr <= wb.data;
		end
	end

	assign regs.tidr = tidr;
	assign regs.pcr = pcr;
	assign regs.spr = spr;
	assign regs.psr = psr;
	assign regs.ppsr = ppsr;

endmodule

/* hdl/operand_stage.sv */
`timescale 1ns/1ps

module operand_stage (
	input logic iCLOCK,
	input logic inRESET,
	input logic event_start,
	input logic next_lock,
	input dispatch_pkg::instr_t instr,
	writeback_if.sink wb,
	input dispatch_pkg::sysreg_view_t regs,
	input logic [dispatch_pkg::DATA_W-1:0] rd0_data,
	input logic [dispatch_pkg::DATA_W-1:0] rd1_data,
	output logic [dispatch_pkg::REG_ADDR_W-1:0] rd0_addr,
	output logic [dispatch_pkg::REG_ADDR_W-1:0] rd1_addr,
	output dispatch_pkg::issued_t issued,
	output logic next_valid
);

	// Hit flag in the top bit, forwarded value below
	function automatic logic [dispatch_pkg::DATA_W:0] forward(
		input logic [dispatch_pkg::REG_ADDR_W-1:0] idx,
		input logic sysreg,
		input logic f_valid,
		input logic [dispatch_pkg::DATA_W-1:0] f_data,
		input logic [dispatch_pkg::REG_ADDR_W-1:0] f_dest,
		input logic f_dest_sysreg,
		input logic f_writeback,
		input logic f_spr_writeback,
		input logic [dispatch_pkg::DATA_W-1:0] f_spr,
		input logic [dispatch_pkg::DATA_W-1:0] f_pc
	);
		logic [dispatch_pkg::DATA_W:0] result;
		result = '0;
		if (f_valid) begin
			if (sysreg && f_dest_sysreg) begin
				if (idx == dispatch_pkg::SYSREG_PCR) begin
					result = {1'b1, f_pc};
				end else if (idx == dispatch_pkg::SYSREG_SPR && f_spr_writeback) begin
					result = {1'b1, f_spr};
				end else if (idx == f_dest && f_writeback) begin
					result = {1'b1, f_data};
				end
			end else if (!sysreg && !f_dest_sysreg && idx == f_dest && f_writeback) begin
				result = {1'b1, f_data};
			end
		end
		return result;
	endfunction

	// Unknown index misses and falls back to the general register
	function automatic logic [dispatch_pkg::DATA_W:0] sysreg_read(
		input logic active,
		input logic [dispatch_pkg::REG_ADDR_W-1:0] idx,
		input dispatch_pkg::sysreg_view_t view,
		input logic [dispatch_pkg::DATA_W-1:0] pc
	);
		logic [dispatch_pkg::DATA_W:0] result;
		result = '0;
		if (active) begin
			case (idx)
				dispatch_pkg::SYSREG_CPUIDR: result = {1'b1, dispatch_pkg::CPUIDR_VALUE};
				dispatch_pkg::SYSREG_TIDR: result = {1'b1, view.tidr};
				dispatch_pkg::SYSREG_PCR: result = {1'b1, pc - dispatch_pkg::PC_READ_OFFSET};
				dispatch_pkg::SYSREG_SPR: result = {1'b1, view.spr};
				dispatch_pkg::SYSREG_PSR: result = {1'b1, view.psr};
				dispatch_pkg::SYSREG_PPSR: result = {1'b1, view.ppsr};
				default: result = '0;
			endcase
		end
		return result;
	endfunction

	logic [dispatch_pkg::DATA_W:0] fwd0, fwd1, sys0, sys1;
	logic [dispatch_pkg::DATA_W-1:0] src0, src1;
	logic valid_q;

	assign rd0_addr = instr.source0;
	assign rd1_addr = instr.source1[dispatch_pkg::REG_ADDR_W-1:0];

	assign fwd0 = forward(instr.source0, instr.source0_sysreg, wb.valid, wb.data,
		wb.destination, wb.destination_sysreg, wb.writeback, wb.spr_writeback, wb.spr, wb.pc);
	assign fwd1 = forward(rd1_addr, instr.source1_sysreg, wb.valid, wb.data,
		wb.destination, wb.destination_sysreg, wb.writeback, wb.spr_writeback, wb.spr, wb.pc);
	assign sys0 = sysreg_read(instr.source0_active, instr.source0, regs, instr.pc);
	assign sys1 = sysreg_read(instr.source1_active, rd1_addr, regs, instr.pc);

	assign src0 = fwd0[dispatch_pkg::DATA_W] ? fwd0[dispatch_pkg::DATA_W-1:0] :
		(instr.source0_sysreg && sys0[dispatch_pkg::DATA_W]) ?
		sys0[dispatch_pkg::DATA_W-1:0] : rd0_data;
	// Immediate beats forwarding on source1
	assign src1 = instr.source1_imm ? instr.source1 :
		fwd1[dispatch_pkg::DATA_W] ? fwd1[dispatch_pkg::DATA_W-1:0] :
		(instr.source1_sysreg && sys1[dispatch_pkg::DATA_W]) ?
		sys1[dispatch_pkg::DATA_W-1:0] : rd1_data;

	// Start flushes even under lock
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= 1'b0;
			issued <= '0;
		end else if (event_start) begin
			valid_q <= 1'b0;
			issued <= '0;
		end else if (!next_lock) begin
			valid_q <= instr.valid;
			issued.cmd <= instr.cmd;
			issued.destination <= instr.destination;
			issued.destination_sysreg <= instr.destination_sysreg;
			issued.writeback <= instr.writeback;
			issued.source0 <= src0;
			issued.source1 <= src1;
			issued.pc <= instr.pc;
		end
	end

	assign next_valid = valid_q && !next_lock;

endmodule

/* hdl/dispatch.sv */
`timescale 1ns/1ps

module dispatch (
	input logic iCLOCK,
	input logic inRESET,
	input logic event_hold,
	input logic event_start,
	input logic event_irq_enter,
	input logic event_irq_return,
	input logic pcr_set,
	input logic [dispatch_pkg::DATA_W-1:0] event_pcr,
	input logic prev_valid,
	input logic [dispatch_pkg::CMD_W-1:0] prev_cmd,
	input logic [dispatch_pkg::REG_ADDR_W-1:0] prev_destination,
	input logic prev_destination_sysreg,
	input logic prev_writeback,
	input logic [dispatch_pkg::REG_ADDR_W-1:0] prev_source0,
	input logic prev_source0_sysreg,
	input logic prev_source0_active,
	input logic [dispatch_pkg::DATA_W-1:0] prev_source1,
	input logic prev_source1_sysreg,
	input logic prev_source1_active,
	input logic prev_source1_imm,
	input logic [dispatch_pkg::DATA_W-1:0] prev_pc,
	output logic previous_lock,
	output logic next_valid,
	output logic [dispatch_pkg::CMD_W-1:0] next_cmd,
	output logic [dispatch_pkg::REG_ADDR_W-1:0] next_destination,
	output logic next_destination_sysreg,
	output logic next_writeback,
	output logic [dispatch_pkg::DATA_W-1:0] next_source0,
	output logic [dispatch_pkg::DATA_W-1:0] next_source1,
	output logic [dispatch_pkg::DATA_W-1:0] next_pc,
	input logic next_lock,
	input logic wb_valid,
	input logic [dispatch_pkg::DATA_W-1:0] wb_data,
	input logic [dispatch_pkg::REG_ADDR_W-1:0] wb_destination,
	input logic wb_destination_sysreg,
	input logic wb_writeback,
	input logic wb_spr_writeback,
	input logic [dispatch_pkg::DATA_W-1:0] wb_spr,
	input logic [dispatch_pkg::DATA_W-1:0] wb_pc,
	output logic [dispatch_pkg::DATA_W-1:0] sysreg_pcr,
	output logic [dispatch_pkg::DATA_W-1:0] sysreg_spr,
	output logic [dispatch_pkg::DATA_W-1:0] sysreg_psr,
	output logic [dispatch_pkg::DATA_W-1:0] sysreg_ppsr,
	output logic [dispatch_pkg::DATA_W-1:0] sysreg_tidr
);

	dispatch_pkg::instr_t instr;
	dispatch_pkg::issued_t issued;
	dispatch_pkg::sysreg_view_t regs;
	logic [dispatch_pkg::REG_ADDR_W-1:0] rd0_addr, rd1_addr;
	logic [dispatch_pkg::DATA_W-1:0] rd0_data, rd1_data;

	writeback_if wb_bus ();

	assign wb_bus.valid = wb_valid;
	assign wb_bus.data = wb_data;
	assign wb_bus.destination = wb_destination;
	assign wb_bus.destination_sysreg = wb_destination_sysreg;
	assign wb_bus.writeback = wb_writeback;
	assign wb_bus.spr_writeback = wb_spr_writeback;
	assign wb_bus.spr = wb_spr;
	assign wb_bus.pc = wb_pc;

	assign instr = '{valid: prev_valid, cmd: prev_cmd, destination: prev_destination,
		destination_sysreg: prev_destination_sysreg, writeback: prev_writeback,
		pc: prev_pc, source0: prev_source0, source0_sysreg: prev_source0_sysreg,
		source0_active: prev_source0_active, source1: prev_source1,
		source1_sysreg: prev_source1_sysreg, source1_active: prev_source1_active,
		source1_imm: prev_source1_imm};

	general_register_file i_grf (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .event_hold(event_hold), .wb(wb_bus),
		.rd0_addr(rd0_addr), .rd0_data(rd0_data), .rd1_addr(rd1_addr), .rd1_data(rd1_data)
	);

	system_register_bank i_bank (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .event_hold(event_hold),
		.event_irq_enter(event_irq_enter), .event_irq_return(event_irq_return),
		.pcr_set(pcr_set), .event_pcr(event_pcr), .wb(wb_bus), .regs(regs)
	);

	operand_stage i_operand (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .event_start(event_start),
		.next_lock(next_lock), .instr(instr), .wb(wb_bus), .regs(regs),
		.rd0_data(rd0_data), .rd1_data(rd1_data), .rd0_addr(rd0_addr),
		.rd1_addr(rd1_addr), .issued(issued), .next_valid(next_valid)
	);

	// No stall of its own, the lock passes straight back
	assign previous_lock = next_lock;

	assign next_cmd = issued.cmd;
	assign next_destination = issued.destination;
	assign next_destination_sysreg = issued.destination_sysreg;
	assign next_writeback = issued.writeback;
	assign next_source0 = issued.source0;
	assign next_source1 = issued.source1;
	assign next_pc = issued.pc;

	assign sysreg_pcr = regs.pcr;
	assign sysreg_spr = regs.spr;
	assign sysreg_psr = regs.psr;
	assign sysreg_ppsr = regs.ppsr;
	assign sysreg_tidr = regs.tidr;

endmodule

/* verification/dispatch_properties.sv */
`timescale 1ns/1ps

module dispatch_properties (
	input logic iCLOCK,
	input logic inRESET,
	input logic event_start,
	input logic next_lock,
	input logic next_valid,
	input logic previous_lock
);

	int unsigned failures = 0;

	// Nothing is offered downstream while the next stage is locked
	lock_blocks_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		next_lock |-> !next_valid)
	else begin
		$error("next_valid high while next_lock is high");
		failures++;
	end

	lock_passes_back: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		previous_lock == next_lock)
	else begin
		$error("previous_lock differs from next_lock");
		failures++;
	end

	start_flushes: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		event_start |=> !next_valid)
	else begin
		$error("next_valid high one cycle after event_start");
		failures++;
	end

endmodule

bind dispatch dispatch_properties i_props (
	.iCLOCK(iCLOCK), .inRESET(inRESET), .event_start(event_start),
	.next_lock(next_lock), .next_valid(next_valid), .previous_lock(previous_lock)
);

/* verification/tb_dispatch.sv */
`timescale 1ns/1ps

module tb_dispatch;

	typedef struct packed {
		logic valid;
		logic [4:0] cmd;
		logic [4:0] destination;
		logic destination_sysreg;
		logic writeback;
		logic [31:0] source0;
		logic [31:0] source1;
		logic [31:0] pc;
	} issue_t;

	typedef struct packed {
		issue_t q;
		logic [31:0] pcr, spr, psr, ppsr, tidr;
	} state_t;

	typedef struct packed {
		logic wb_valid, wb_writeback, wb_dsys, wb_spr_wb;
		logic [4:0] wb_dest;
		logic [31:0] wb_data, wb_spr, wb_pc;
		logic valid, dsys, writeback, s0_sys, s0_act, s1_sys, s1_act, s1_imm;
		logic [4:0] cmd, dest, source0;
		logic [31:0] source1, pc, event_pcr;
		logic lock, hold, start, irq_enter, irq_return, pcr_set;
		// Outputs expected once this row is clocked in
		state_t exp;
	} row_t;

	logic iCLOCK, inRESET;
	logic event_hold, event_start, event_irq_enter, event_irq_return, pcr_set;
	logic [31:0] event_pcr;
	logic prev_valid, prev_destination_sysreg, prev_writeback;
	logic [4:0] prev_cmd, prev_destination, prev_source0;
	logic prev_source0_sysreg, prev_source0_active;
	logic prev_source1_sysreg, prev_source1_active, prev_source1_imm;
	logic [31:0] prev_source1, prev_pc;
	logic previous_lock, next_valid, next_destination_sysreg, next_writeback, next_lock;
	logic [4:0] next_cmd, next_destination;
	logic [31:0] next_source0, next_source1, next_pc;
	logic wb_valid, wb_destination_sysreg, wb_writeback, wb_spr_writeback;
	logic [4:0] wb_destination;
	logic [31:0] wb_data, wb_spr, wb_pc;
	logic [31:0] sysreg_pcr, sysreg_spr, sysreg_psr, sysreg_ppsr, sysreg_tidr;

	row_t tbl[$];
	row_t r;
	state_t m;
	logic [31:0] m_gpr [32];
	integer seed = 32'h546d;
	bit table_ready = 1'b0;

	dispatch i_dut (.*);

	initial begin
		iCLOCK = 1'b0;
		forever #5 iCLOCK = ~iCLOCK;
	end

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	// Forwarded value first, then a known system register, then the register file
	function automatic logic [31:0] expected_operand(input logic [4:0] idx, input logic sys,
		input logic act, input row_t s);
		logic [31:0] v;
		v = m_gpr[idx];
		if (sys && act) begin
			case (idx)
				dispatch_pkg::SYSREG_CPUIDR: v = dispatch_pkg::CPUIDR_VALUE;
				dispatch_pkg::SYSREG_TIDR: v = m.tidr;
				dispatch_pkg::SYSREG_PCR: v = s.pc - 32'd4;
				dispatch_pkg::SYSREG_SPR: v = m.spr;
				dispatch_pkg::SYSREG_PSR: v = m.psr;
				dispatch_pkg::SYSREG_PPSR: v = m.ppsr;
				default: v = m_gpr[idx];
			endcase
		end
		if (s.wb_valid && sys && s.wb_dsys) begin
			if (idx == dispatch_pkg::SYSREG_PCR)
				v = s.wb_pc;
			else if (idx == dispatch_pkg::SYSREG_SPR && s.wb_spr_wb)
				v = s.wb_spr;
			else if (idx == s.wb_dest && s.wb_writeback)
				v = s.wb_data;
		end else if (s.wb_valid && !sys && !s.wb_dsys && idx == s.wb_dest && s.wb_writeback) begin
			v = s.wb_data;
		end
		return v;
	endfunction

	task automatic advance_model(inout row_t s);
		logic [31:0] op0, op1;
		logic sys_wr;
		op0 = expected_operand(s.source0, s.s0_sys, s.s0_act, s);
		op1 = s.s1_imm ? s.source1 : expected_operand(s.source1[4:0], s.s1_sys, s.s1_act, s);
		sys_wr = s.wb_valid && s.wb_writeback && s.wb_dsys && !s.hold;
		if (s.start)
			m.q = '0;
		else if (!s.lock)
			m.q = {s.valid, s.cmd, s.dest, s.dsys, s.writeback, op0, op1, s.pc};
		if (s.wb_valid && s.wb_writeback && !s.wb_dsys && !s.hold)
			m_gpr[s.wb_dest] = s.wb_data;
		if (sys_wr && s.wb_dest == dispatch_pkg::SYSREG_TIDR)
			m.tidr = s.wb_data;
		if (s.pcr_set)
			m.pcr = s.event_pcr;
		else if (s.wb_valid && !s.hold)
			m.pcr = s.wb_pc;
		if (s.wb_valid && s.wb_spr_wb && !s.hold)
			m.spr = s.wb_spr;
		else if (sys_wr && s.wb_dest == dispatch_pkg::SYSREG_SPR)
			m.spr = s.wb_data;
		// Entry saves and masks the status, return brings the saved copy back
		if (s.irq_enter) begin
			m.ppsr = m.psr;
			// Bits 6, 5 and 2 clear
			m.psr = m.psr & ~32'h0000_0064;
		end else begin
			if (s.irq_return)
				m.psr = m.ppsr;
			else if (sys_wr && s.wb_dest == dispatch_pkg::SYSREG_PSR)
				m.psr = s.wb_data;
			if (sys_wr && s.wb_dest == dispatch_pkg::SYSREG_PPSR)
				m.ppsr = s.wb_data;
		end
		s.exp = m;
	endtask

	task automatic push_row();
		advance_model(r);
		tbl.push_back(r);
		r = '0;
	endtask

	task automatic set_writeback(input logic [4:0] dest, input logic [31:0] data,
		input logic sys);
		r.wb_valid = 1'b1;
		r.wb_writeback = 1'b1;
		r.wb_dsys = sys;
		r.wb_dest = dest;
		r.wb_data = data;
		r.wb_pc = rand32();
	endtask

	task automatic set_instr(input logic [4:0] src0, input logic [31:0] src1);
		logic [31:0] t;
		t = rand32();
		r.valid = 1'b1;
		r.cmd = t[4:0];
		r.dest = t[9:5];
		r.writeback = t[10];
		r.dsys = t[11];
		r.source0 = src0;
		r.source1 = src1;
		r.pc = rand32();
	endtask

	task automatic build_table();
		logic [31:0] t;
		m = '0;
		r = '0;
		for (int k = 0; k < 32; k++) begin
			m_gpr[k] = '0;
		end
		for (int k = 1; k <= 8; k++) begin
			set_writeback(5'(k), rand32(), 1'b0);
			push_row();
		end
		for (int k = 1; k <= 8; k++) begin
			set_instr(5'(k), 32'(9 - k));
			push_row();
		end
		// Same-cycle writeback into both sources, then PCR against a sysreg writeback
		set_writeback(5'd12, rand32(), 1'b0);
		set_instr(5'd12, 32'd12);
		push_row();
		set_writeback(5'd7, rand32(), 1'b1);
		set_instr(dispatch_pkg::SYSREG_PCR, 32'd3);
		r.s0_sys = 1'b1;
		r.s0_act = 1'b1;
		push_row();
		set_writeback(5'd3, rand32(), 1'b0);
		t = rand32();
		set_instr(5'd2, {t[31:5], 5'd3});
		r.s1_imm = 1'b1;
		push_row();
		set_instr(dispatch_pkg::SYSREG_CPUIDR, 32'(dispatch_pkg::SYSREG_PCR));
		r.s0_sys = 1'b1;
		r.s0_act = 1'b1;
		r.s1_sys = 1'b1;
		r.s1_act = 1'b1;
		push_row();
		r.wb_valid = 1'b1;
		r.wb_spr_wb = 1'b1;
		r.wb_spr = rand32();
		r.wb_pc = rand32();
		push_row();
		set_instr(5'd4, 32'(dispatch_pkg::SYSREG_SPR));
		r.s1_sys = 1'b1;
		r.s1_act = 1'b1;
		push_row();
		// Two locked cycles, then release
		for (int k = 0; k < 3; k++) begin
			set_instr(5'(k + 1), 32'(k + 5));
			r.lock = (k < 2);
			push_row();
		end
		set_writeback(5'd1, rand32(), 1'b0);
		r.hold = 1'b1;
		push_row();
		set_instr(5'd1, 32'd1);
		push_row();
		set_writeback(dispatch_pkg::SYSREG_PSR, 32'h0000_00ff, 1'b1);
		push_row();
		r.irq_enter = 1'b1;
		push_row();
		set_writeback(dispatch_pkg::SYSREG_PSR, 32'h0000_0a00, 1'b1);
		push_row();
		r.irq_return = 1'b1;
		push_row();
		r.pcr_set = 1'b1;
		r.event_pcr = rand32();
		push_row();
		// TIDR write, then TIDR and PPSR as sources
		set_writeback(dispatch_pkg::SYSREG_TIDR, rand32(), 1'b1);
		push_row();
		set_instr(dispatch_pkg::SYSREG_TIDR, 32'(dispatch_pkg::SYSREG_PPSR));
		r.s0_sys = 1'b1;
		r.s0_act = 1'b1;
		r.s1_sys = 1'b1;
		r.s1_act = 1'b1;
		push_row();
		set_instr(5'd2, 32'd3);
		r.start = 1'b1;
		push_row();
		set_instr(5'd4, 32'd5);
		push_row();
		set_instr(5'd6, 32'd7);
		r.start = 1'b1;
		r.lock = 1'b1;
		push_row();
		push_row();
		for (int k = 0; k < 24; k++) begin
			t = rand32();
			set_writeback(t[4:0], rand32(), t[5]);
			set_instr(t[10:6], rand32());
			r.wb_valid = t[11];
			r.wb_writeback = t[12];
			r.wb_spr_wb = t[13] & t[14];
			r.wb_spr = rand32();
			r.valid = t[15];
			r.s0_sys = t[16];
			r.s0_act = t[17];
			r.s1_sys = t[18];
			r.s1_act = t[19];
			r.s1_imm = t[20] & t[21];
			r.lock = t[22] & t[23];
			r.hold = t[24] & t[25];
			r.start = &t[28:26];
			r.irq_enter = &t[31:29];
			r.irq_return = t[31] & t[30] & ~t[29];
			push_row();
		end
	endtask

	task automatic drive(input row_t s);
		wb_valid <= s.wb_valid;
		wb_writeback <= s.wb_writeback;
		wb_destination_sysreg <= s.wb_dsys;
		wb_spr_writeback <= s.wb_spr_wb;
		wb_destination <= s.wb_dest;
		wb_data <= s.wb_data;
		wb_spr <= s.wb_spr;
		wb_pc <= s.wb_pc;
		prev_valid <= s.valid;
		prev_cmd <= s.cmd;
		prev_destination <= s.dest;
		prev_destination_sysreg <= s.dsys;
		prev_writeback <= s.writeback;
		prev_source0 <= s.source0;
		prev_source0_sysreg <= s.s0_sys;
		prev_source0_active <= s.s0_act;
		prev_source1 <= s.source1;
		prev_source1_sysreg <= s.s1_sys;
		prev_source1_active <= s.s1_act;
		prev_source1_imm <= s.s1_imm;
		prev_pc <= s.pc;
		next_lock <= s.lock;
		event_hold <= s.hold;
		event_start <= s.start;
		event_irq_enter <= s.irq_enter;
		event_irq_return <= s.irq_return;
		pcr_set <= s.pcr_set;
		event_pcr <= s.event_pcr;
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		assert (actual === expected) else begin
			$display("Error: at %0t ns %s expected %h, actual %h", $time, name, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1, "Output mismatch on %s", name);
		end
	endtask

	task automatic check_outputs(input state_t e, input logic lock);
		check_value("previous_lock", 32'(previous_lock), 32'(lock));
		check_value("next_valid", 32'(next_valid), 32'(e.q.valid && !lock));
		check_value("next_cmd", 32'(next_cmd), 32'(e.q.cmd));
		check_value("next_destination", 32'(next_destination), 32'(e.q.destination));
		check_value("next_destination_sysreg", 32'(next_destination_sysreg),
			32'(e.q.destination_sysreg));
		check_value("next_writeback", 32'(next_writeback), 32'(e.q.writeback));
		check_value("next_source0", next_source0, e.q.source0);
		check_value("next_source1", next_source1, e.q.source1);
		check_value("next_pc", next_pc, e.q.pc);
		check_value("sysreg_pcr", sysreg_pcr, e.pcr);
		check_value("sysreg_spr", sysreg_spr, e.spr);
		check_value("sysreg_psr", sysreg_psr, e.psr);
		check_value("sysreg_ppsr", sysreg_ppsr, e.ppsr);
		check_value("sysreg_tidr", sysreg_tidr, e.tidr);
	endtask

	initial begin
		row_t cur;
		state_t last;
		inRESET = 1'b0;
		drive('0);
		build_table();
		table_ready = 1'b1;
		last = '0;
		repeat (8) @(posedge iCLOCK);
		inRESET <= 1'b1;
		// Outputs seen at each falling edge belong to the row before
		for (int i = 0; i <= tbl.size(); i++) begin
			if (i < tbl.size())
				cur = tbl[i];
			else
				cur = '0;
			@(posedge iCLOCK);
			drive(cur);
			@(negedge iCLOCK);
			check_outputs(last, cur.lock);
			last = cur.exp;
		end
		if (i_dut.i_props.failures == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("Bound property checks failed %0d times", i_dut.i_props.failures);
			$display("RESULT: FAIL");
			$fatal(1, "Property failures");
		end
	end

	initial begin
		wait (table_ready);
		#((tbl.size() + 20) * 10);
		$display("Timeout: the run did not finish within %0d cycles", tbl.size() + 20);
		$display("RESULT: FAIL");
		$fatal(1, "Watchdog expired");
	end

endmodule

/* flist.f */
hdl/dispatch_pkg.sv
hdl/writeback_if.sv
hdl/general_register_file.sv
hdl/system_register_bank.sv
hdl/operand_stage.sv
hdl/dispatch.sv
verification/dispatch_properties.sv
verification/tb_dispatch.sv

/* Makefile */
VERILATOR = verilator
FLAGS = --binary --timing --assert
TOP = tb_dispatch
FILELIST = flist.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)
